// ==== common/MemorySystem_macros.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths, serial depth and I/O address map of the memory system.
// Included by the type package and by any module that reads the map.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef MEMORY_SYSTEM_MACROS_SVH
`define MEMORY_SYSTEM_MACROS_SVH

// Word and address widths
`define MEM_ADDR_WIDTH 32
`define MEM_DATA_WIDTH 32

// 3 bits gives 8 outstanding serials
`define MEM_SERIAL_WIDTH 3

// I/O window decoded on the top nibble
`define IO_BASE_ADDR 32'h4000_0000
`define IO_TX_OFFSET 32'h0000_0000
`define IO_STATUS_OFFSET 32'h0000_0004

`define PERF_COUNT_WIDTH 16

`endif

// ==== common/MemorySystemTypes.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the memory system: addresses, data words, serials,
// counter values and the client name used for read routing.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "MemorySystem_macros.svh"

package MemorySystemTypes;

    // Physical address
    typedef logic [`MEM_ADDR_WIDTH-1:0] PhyAddrPath;

    // One memory word
    typedef logic [`MEM_DATA_WIDTH-1:0] MemoryEntryDataPath;

    // Serials handed out by the memory
    typedef logic [`MEM_SERIAL_WIDTH-1:0] MemAccessSerial;
    typedef logic [`MEM_SERIAL_WIDTH-1:0] MemWriteSerial;

    // One transmit character
    typedef logic [7:0] SerialDataPath;

    typedef logic [`PERF_COUNT_WIDTH-1:0] PerfCountPath;

    // Owner of an access
    typedef enum logic {
        CLIENT_FETCH,
        CLIENT_DATA
    } MemClient;

endpackage

// ==== hw/MemoryAccessController/ReadSerialTable.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tracks which client owns each outstanding read serial, so returned
// words find their client whatever order the memory answers in.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "MemorySystem_macros.svh"

module ReadSerialTable (
    input  logic clk,
    input  logic rstN,
    input  logic alloc,
    input  MemorySystemTypes::MemAccessSerial allocSerial,
    input  MemorySystemTypes::MemClient allocClient,
    input  logic lookupValid,
    input  MemorySystemTypes::MemAccessSerial lookupSerial,
    output MemorySystemTypes::MemClient lookupClient,
    output logic lookupHit
);
    import MemorySystemTypes::*;

    localparam int SERIAL_NUM = 1 << `MEM_SERIAL_WIDTH;

    logic [SERIAL_NUM-1:0] entryValid;
    MemClient owner [SERIAL_NUM];

    // Stray responses miss here and are dropped
    assign lookupHit = lookupValid && entryValid[lookupSerial];
    assign lookupClient = owner[lookupSerial];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            entryValid <= '0;
        end else begin
            // A new alloc on the same serial overrides the free
            if (lookupHit) begin
                entryValid[lookupSerial] <= 1'b0;
            end
            if (alloc) begin
                entryValid[allocSerial] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            owner[allocSerial] <= allocClient;
        end
    end

endmodule

// ==== hw/MemoryAccessController/MemoryAccessController.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serves the fetch and data clients over four-phase req/ack handshakes.
// Arbitrates the external port round robin, diverts the I/O window to the
// I/O unit and routes read data back by serial.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "MemorySystem_macros.svh"

module MemoryAccessController (
    input  logic clk,
    input  logic rstN,
    input  logic fetchReq,
    input  MemorySystemTypes::PhyAddrPath fetchAddr,
    output logic fetchAck,
    output MemorySystemTypes::MemoryEntryDataPath fetchData,
    input  logic dataReq,
    input  logic dataWE,
    input  MemorySystemTypes::PhyAddrPath dataAddr,
    input  MemorySystemTypes::MemoryEntryDataPath dataWriteData,
    output logic dataAck,
    output MemorySystemTypes::MemoryEntryDataPath dataReadData,
    input  MemorySystemTypes::MemAccessSerial nextMemReadSerial,
    input  MemorySystemTypes::MemWriteSerial nextMemWriteSerial,
    input  logic memReadDataReady,
    input  MemorySystemTypes::MemAccessSerial memReadSerial,
    input  MemorySystemTypes::MemoryEntryDataPath memReadData,
    input  logic memAccessResponseValid,
    input  MemorySystemTypes::MemWriteSerial memAccessResponseSerial,
    input  logic memAccessReadBusy,
    input  logic memAccessWriteBusy,
    output MemorySystemTypes::PhyAddrPath memAccessAddr,
    output MemorySystemTypes::MemoryEntryDataPath memAccessWriteData,
    output logic memAccessRE,
    output logic memAccessWE,
    output logic ioWE,
    output logic ioRE,
    output MemorySystemTypes::PhyAddrPath ioOffset,
    output MemorySystemTypes::MemoryEntryDataPath ioWriteData,
    input  MemorySystemTypes::MemoryEntryDataPath ioReadData,
    output logic readDone,
    output logic writeDone,
    output logic ioDone
);
    import MemorySystemTypes::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_FLIGHT,
        ST_ACKED
    } ClientState;

    localparam PhyAddrPath IO_BASE = `IO_BASE_ADDR;

    ClientState fetchState;
    ClientState dataState;
    logic dataIsIo;
    logic ioPending;
    logic preferData;
    MemWriteSerial dataWriteSerial;
    logic fetchWant;
    logic dataWant;
    logic fetchGrant;
    logic dataGrant;
    logic fetchReturn;
    logic dataReturn;
    logic writeReturn;
    MemClient lookupClient;
    logic lookupHit;

    assign dataIsIo = dataAddr[`MEM_ADDR_WIDTH-1 -: 4] == IO_BASE[`MEM_ADDR_WIDTH-1 -: 4];

    // A client only competes when its enable is free
    assign fetchWant = fetchState == ST_WAIT && !memAccessReadBusy;
    assign dataWant = dataState == ST_WAIT &&
        (dataWE ? !memAccessWriteBusy : !memAccessReadBusy);
    assign fetchGrant = fetchWant && !(dataWant && preferData);
    assign dataGrant = dataWant && !fetchGrant;

    assign memAccessRE = fetchGrant || (dataGrant && !dataWE);
    assign memAccessWE = dataGrant && dataWE;
    assign memAccessAddr = dataGrant ? dataAddr : fetchAddr;
    assign memAccessWriteData = dataWriteData;

    // I/O pulses go out in the accept cycle
    assign ioRE = dataState == ST_IDLE && dataReq && dataIsIo && !dataWE;
    assign ioWE = dataState == ST_IDLE && dataReq && dataIsIo && dataWE;
    assign ioOffset = dataAddr - IO_BASE;
    assign ioWriteData = dataWriteData;

    ReadSerialTable readSerialTable (
        .clk, .rstN,
        .alloc(memAccessRE),
        .allocSerial(nextMemReadSerial),
        .allocClient(dataGrant ? CLIENT_DATA : CLIENT_FETCH),
        .lookupValid(memReadDataReady),
        .lookupSerial(memReadSerial),
        .lookupClient(lookupClient),
        .lookupHit(lookupHit)
    );

    assign fetchReturn = fetchState == ST_FLIGHT && lookupHit && lookupClient == CLIENT_FETCH;
    assign dataReturn = dataState == ST_FLIGHT && !ioPending && !dataWE &&
        lookupHit && lookupClient == CLIENT_DATA;
    assign writeReturn = dataState == ST_FLIGHT && !ioPending && dataWE &&
        memAccessResponseValid && memAccessResponseSerial == dataWriteSerial;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            fetchState <= ST_IDLE;
            fetchAck <= 1'b0;
        end else begin
            case (fetchState)
                ST_IDLE: if (fetchReq) fetchState <= ST_WAIT;
                ST_WAIT: if (fetchGrant) fetchState <= ST_FLIGHT;
                ST_FLIGHT: begin
                    if (fetchReturn) begin
                        fetchState <= ST_ACKED;
                        fetchAck <= 1'b1;
                    end
                end
                default: begin
                    if (!fetchReq) begin
                        fetchState <= ST_IDLE;
                        fetchAck <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            dataState <= ST_IDLE;
            dataAck <= 1'b0;
            ioPending <= 1'b0;
        end else begin
            case (dataState)
                ST_IDLE: begin
                    if (dataReq) begin
                        dataState <= dataIsIo ? ST_FLIGHT : ST_WAIT;
                        ioPending <= dataIsIo;
                    end
                end
                ST_WAIT: if (dataGrant) dataState <= ST_FLIGHT;
                ST_FLIGHT: begin
                    if (ioPending || dataReturn || writeReturn) begin
                        dataState <= ST_ACKED;
                        dataAck <= 1'b1;
                        ioPending <= 1'b0;
                    end
                end
                default: begin
                    if (!dataReq) begin
                        dataState <= ST_IDLE;
                        dataAck <= 1'b0;
                    end
                end
            endcase
        end
    end

    // Round robin starting with fetch after reset
    always_ff @(posedge clk) begin
        if (!rstN) begin
            preferData <= 1'b0;
            readDone <= 1'b0;
            writeDone <= 1'b0;
            ioDone <= 1'b0;
        end else begin
            if (fetchGrant) preferData <= 1'b1;
            else if (dataGrant) preferData <= 1'b0;
            readDone <= fetchReturn || dataReturn;
            writeDone <= writeReturn;
            ioDone <= dataState == ST_FLIGHT && ioPending && dataWE &&
                ioOffset == `IO_TX_OFFSET;
        end
    end

    always_ff @(posedge clk) begin
        if (fetchReturn) fetchData <= memReadData;
        if (dataReturn) dataReadData <= memReadData;
        else if (dataState == ST_FLIGHT && ioPending) dataReadData <= ioReadData;
        if (dataGrant && dataWE) dataWriteSerial <= nextMemWriteSerial;
    end

endmodule

// ==== hw/IO_Unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serial output unit. Writes to the transmit offset emit one character,
// and the status offset reads back the number of characters sent.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "MemorySystem_macros.svh"

module IO_Unit (
    input  logic clk,
    input  logic rstN,
    input  logic ioWE,
    input  logic ioRE,
    input  MemorySystemTypes::PhyAddrPath ioOffset,
    input  MemorySystemTypes::MemoryEntryDataPath ioWriteData,
    output MemorySystemTypes::MemoryEntryDataPath ioReadData,
    output logic serialWE,
    output MemorySystemTypes::SerialDataPath serialWriteData
);
    import MemorySystemTypes::*;

    logic txWrite;
    MemoryEntryDataPath sentCount;

    assign txWrite = ioWE && ioOffset == `IO_TX_OFFSET;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            serialWE <= 1'b0;
            sentCount <= '0;
        end else begin
            serialWE <= txWrite;
            if (txWrite) sentCount <= sentCount + 1'b1;
        end
    end

    // Read data is valid the cycle after ioRE
    always_ff @(posedge clk) begin
        if (txWrite) serialWriteData <= ioWriteData[7:0];
        if (ioRE) begin
            ioReadData <= (ioOffset == `IO_STATUS_OFFSET) ? sentCount : '0;
        end
    end

endmodule

// ==== hw/PerformanceCounter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Saturating counts of completed memory reads, memory writes and I/O
// transmit writes, fed by one-cycle pulses from the access controller.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module PerformanceCounter (
    input  logic clk,
    input  logic rstN,
    input  logic readDone,
    input  logic writeDone,
    input  logic ioDone,
    output MemorySystemTypes::PerfCountPath readCount,
    output MemorySystemTypes::PerfCountPath writeCount,
    output MemorySystemTypes::PerfCountPath ioWriteCount
);
    import MemorySystemTypes::*;

    // Sticks at all ones
    function automatic PerfCountPath satInc(input PerfCountPath value);
        return (value == '1) ? value : value + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN) begin
            readCount <= '0;
            writeCount <= '0;
            ioWriteCount <= '0;
        end else begin
            if (readDone) readCount <= satInc(readCount);
            if (writeDone) writeCount <= satInc(writeCount);
            if (ioDone) ioWriteCount <= satInc(ioWriteCount);
        end
    end

endmodule

// ==== hw/MemorySystem.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the memory system. Connects the access controller, the
// serial I/O unit and the performance counter to the external memory port.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module MemorySystem (
    input  logic clk,
    input  logic rstN,
    input  logic fetchReq,
    input  MemorySystemTypes::PhyAddrPath fetchAddr,
    output logic fetchAck,
    output MemorySystemTypes::MemoryEntryDataPath fetchData,
    input  logic dataReq,
    input  logic dataWE,
    input  MemorySystemTypes::PhyAddrPath dataAddr,
    input  MemorySystemTypes::MemoryEntryDataPath dataWriteData,
    output logic dataAck,
    output MemorySystemTypes::MemoryEntryDataPath dataReadData,
    input  MemorySystemTypes::MemAccessSerial nextMemReadSerial,
    input  MemorySystemTypes::MemWriteSerial nextMemWriteSerial,
    input  logic memReadDataReady,
    input  MemorySystemTypes::MemAccessSerial memReadSerial,
    input  MemorySystemTypes::MemoryEntryDataPath memReadData,
    input  logic memAccessResponseValid,
    input  MemorySystemTypes::MemWriteSerial memAccessResponseSerial,
    input  logic memAccessReadBusy,
    input  logic memAccessWriteBusy,
    output MemorySystemTypes::PhyAddrPath memAccessAddr,
    output MemorySystemTypes::MemoryEntryDataPath memAccessWriteData,
    output logic memAccessRE,
    output logic memAccessWE,
    output logic serialWE,
    output MemorySystemTypes::SerialDataPath serialWriteData,
    output MemorySystemTypes::PerfCountPath readCount,
    output MemorySystemTypes::PerfCountPath writeCount,
    output MemorySystemTypes::PerfCountPath ioWriteCount
);
    import MemorySystemTypes::*;

    // Controller to I/O unit
    logic ioWE;
    logic ioRE;
    PhyAddrPath ioOffset;
    MemoryEntryDataPath ioWriteData;
    MemoryEntryDataPath ioReadData;

    // Completion pulses
    logic readDone;
    logic writeDone;
    logic ioDone;

    MemoryAccessController memoryAccessController (
        .clk, .rstN,
        .fetchReq, .fetchAddr, .fetchAck, .fetchData,
        .dataReq, .dataWE, .dataAddr, .dataWriteData, .dataAck, .dataReadData,
        .nextMemReadSerial, .nextMemWriteSerial,
        .memReadDataReady, .memReadSerial, .memReadData,
        .memAccessResponseValid, .memAccessResponseSerial,
        .memAccessReadBusy, .memAccessWriteBusy,
        .memAccessAddr, .memAccessWriteData, .memAccessRE, .memAccessWE,
        .ioWE, .ioRE, .ioOffset, .ioWriteData, .ioReadData,
        .readDone, .writeDone, .ioDone
    );

    IO_Unit ioUnit (
        .clk, .rstN,
        .ioWE, .ioRE, .ioOffset, .ioWriteData, .ioReadData,
        .serialWE, .serialWriteData
    );

    PerformanceCounter perfCounter (
        .clk, .rstN,
        .readDone, .writeDone, .ioDone,
        .readCount, .writeCount, .ioWriteCount
    );

endmodule

// ==== testbench/ClockGen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock at a 100 ns period, with reset held low for 10 cycles.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module ClockGen (
    output logic clk,
    output logic rstN
);
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (10) @(posedge clk);
        #1 rstN = 1'b1;
    end
endmodule

// ==== testbench/MemoryModel.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word memory on the external port. Answers reads and writes after random
// delays, so reads can return out of order, and raises busy at random.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module MemoryModel (
    input  logic clk,
    input  logic rstN,
    input  MemorySystemTypes::PhyAddrPath memAccessAddr,
    input  MemorySystemTypes::MemoryEntryDataPath memAccessWriteData,
    input  logic memAccessRE,
    input  logic memAccessWE,
    output MemorySystemTypes::MemAccessSerial nextMemReadSerial,
    output MemorySystemTypes::MemWriteSerial nextMemWriteSerial,
    output logic memReadDataReady,
    output MemorySystemTypes::MemAccessSerial memReadSerial,
    output MemorySystemTypes::MemoryEntryDataPath memReadData,
    output logic memAccessResponseValid,
    output MemorySystemTypes::MemWriteSerial memAccessResponseSerial,
    output logic memAccessReadBusy,
    output logic memAccessWriteBusy
);
    integer seed = 32'hbb84_bb60;
    logic [31:0] mem [logic [31:0]];
    logic [7:0] pendValid;
    logic [31:0] pendData [8];
    int pendDelay [8];
    logic wrValid;
    logic [2:0] wrSerial;
    int wrDelay;

    // Unwritten words follow the address pattern
    function automatic logic [31:0] readWord(input logic [31:0] addr);
        return mem.exists(addr) ? mem[addr] : addr ^ 32'hA5A5_A5A5;
    endfunction

    always @(posedge clk) begin
        int i;
        int start;
        int pick;
        if (!rstN) begin
            nextMemReadSerial <= '0;
            nextMemWriteSerial <= '0;
            memReadDataReady <= 1'b0;
            memReadSerial <= '0;
            memReadData <= '0;
            memAccessResponseValid <= 1'b0;
            memAccessResponseSerial <= '0;
            memAccessReadBusy <= 1'b0;
            memAccessWriteBusy <= 1'b0;
            pendValid = '0;
            wrValid = 1'b0;
        end else begin
            memReadDataReady <= 1'b0;
            memAccessResponseValid <= 1'b0;
            // Random scan start lets later reads overtake earlier ones
            pick = -1;
            start = {$random(seed)} % 8;
            for (i = 0; i < 8; i++) begin
                if (pick < 0 && pendValid[(start + i) % 8] && pendDelay[(start + i) % 8] == 0)
                    pick = (start + i) % 8;
            end
            if (pick >= 0) begin
                memReadDataReady <= 1'b1;
                memReadSerial <= pick[2:0];
                memReadData <= pendData[pick];
                pendValid[pick] = 1'b0;
            end
            for (i = 0; i < 8; i++) begin
                if (pendValid[i] && pendDelay[i] > 0) pendDelay[i] = pendDelay[i] - 1;
            end
            if (wrValid && wrDelay == 0) begin
                memAccessResponseValid <= 1'b1;
                memAccessResponseSerial <= wrSerial;
                wrValid = 1'b0;
            end else if (wrValid) begin
                wrDelay = wrDelay - 1;
            end
            if (memAccessRE) begin
                pendValid[nextMemReadSerial] = 1'b1;
                pendData[nextMemReadSerial] = readWord(memAccessAddr);
                pendDelay[nextMemReadSerial] = {$random(seed)} % 6;
                nextMemReadSerial <= nextMemReadSerial + 3'd1;
            end
            if (memAccessWE) begin
                mem[memAccessAddr] = memAccessWriteData;
                wrValid = 1'b1;
                wrSerial = nextMemWriteSerial;
                wrDelay = {$random(seed)} % 6;
                nextMemWriteSerial <= nextMemWriteSerial + 3'd1;
            end
            memAccessReadBusy <= ({$random(seed)} % 4) == 0;
            memAccessWriteBusy <= ({$random(seed)} % 4) == 0;
        end
    end
endmodule

// ==== testbench/MemorySystem_chk.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Protocol assertions on the memory system ports, bound into the top level.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module MemorySystemChk (
    input logic clk,
    input logic rstN,
    input logic memAccessRE,
    input logic memAccessWE,
    input logic memAccessReadBusy,
    input logic memAccessWriteBusy,
    input logic fetchReq,
    input logic fetchAck,
    input logic dataReq,
    input logic dataAck,
    input logic serialWE
);
    reSoloWe: assert property (@(posedge clk) disable iff (!rstN)
        !(memAccessRE && memAccessWE))
        else $error("read and write enables high together");

    reNotBusy: assert property (@(posedge clk) disable iff (!rstN)
        !(memAccessRE && memAccessReadBusy))
        else $error("read enable while read busy");

    weNotBusy: assert property (@(posedge clk) disable iff (!rstN)
        !(memAccessWE && memAccessWriteBusy))
        else $error("write enable while write busy");

    // The client may drop req as soon as it sees the ack
    fetchAckReq: assert property (@(posedge clk) disable iff (!rstN)
        $rose(fetchAck) |-> $past(fetchReq))
        else $error("fetch ack rose without request");

    dataAckReq: assert property (@(posedge clk) disable iff (!rstN)
        $rose(dataAck) |-> $past(dataReq))
        else $error("data ack rose without request");

    serialPulse: assert property (@(posedge clk) disable iff (!rstN)
        serialWE |=> !serialWE)
        else $error("serial write enable held two cycles");
endmodule

bind MemorySystem MemorySystemChk memorySystemChk (
    .clk(clk), .rstN(rstN),
    .memAccessRE(memAccessRE), .memAccessWE(memAccessWE),
    .memAccessReadBusy(memAccessReadBusy), .memAccessWriteBusy(memAccessWriteBusy),
    .fetchReq(fetchReq), .fetchAck(fetchAck),
    .dataReq(dataReq), .dataAck(dataAck),
    .serialWE(serialWE)
);

// ==== testbench/MemorySystemTb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the memory system. Runs a table of fetch, data and I/O
// accesses against a random-latency memory and checks every result.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "MemorySystem_macros.svh"

module MemorySystemTb;
    import MemorySystemTypes::*;

    typedef struct packed {
        logic isData;
        logic we;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] expData;
        logic conc;
    } TestRow;

    localparam logic [31:0] IO_TX = `IO_BASE_ADDR + `IO_TX_OFFSET;
    localparam logic [31:0] IO_STATUS = `IO_BASE_ADDR + `IO_STATUS_OFFSET;
    localparam int NUM_ROWS = 10;
    localparam int CYCLE_LIMIT = NUM_ROWS * 40 + 10;

    logic clk, rstN, fetchReq, fetchAck, dataReq, dataWE, dataAck;
    PhyAddrPath fetchAddr, dataAddr, memAccessAddr;
    MemoryEntryDataPath fetchData, dataWriteData, dataReadData, memReadData;
    MemoryEntryDataPath memAccessWriteData;
    MemAccessSerial nextMemReadSerial, memReadSerial;
    MemWriteSerial nextMemWriteSerial, memAccessResponseSerial;
    logic memReadDataReady, memAccessResponseValid, memAccessReadBusy, memAccessWriteBusy;
    logic memAccessRE, memAccessWE, serialWE;
    SerialDataPath serialWriteData;
    PerfCountPath readCount, writeCount, ioWriteCount;

    TestRow table_ [NUM_ROWS];
    int errors = 0;
    int cycles = 0;
    int serialPulses = 0;
    int ioWriteLeaks = 0;
    logic ioActive = 1'b0;
    logic [7:0] serialByte;

    ClockGen clockGen (.clk, .rstN);

    MemorySystem uut (.*);

    MemoryModel memoryModel (
        .clk, .rstN, .memAccessAddr, .memAccessWriteData, .memAccessRE, .memAccessWE,
        .nextMemReadSerial, .nextMemWriteSerial, .memReadDataReady, .memReadSerial,
        .memReadData, .memAccessResponseValid, .memAccessResponseSerial,
        .memAccessReadBusy, .memAccessWriteBusy
    );

    function automatic logic [31:0] initContent(input logic [31:0] addr);
        return addr ^ 32'hA5A5_A5A5;
    endfunction

    // Serial and I/O side effects seen mid-cycle
    always @(negedge clk) begin
        if (serialWE) begin
            serialPulses = serialPulses + 1;
            serialByte = serialWriteData;
        end
        if (ioActive && memAccessWE) ioWriteLeaks = ioWriteLeaks + 1;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles waiting for an ack", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic fetchAccess(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        #1 fetchReq = 1'b1;
        fetchAddr = addr;
        do begin
            @(posedge clk);
            #1;
        end while (!fetchAck);
        data = fetchData;
        fetchReq = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (fetchAck);
    endtask

    task automatic dataAccess(input logic we, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] data);
        @(posedge clk);
        #1 dataReq = 1'b1;
        dataWE = we;
        dataAddr = addr;
        dataWriteData = wdata;
        do begin
            @(posedge clk);
            #1;
        end while (!dataAck);
        data = dataReadData;
        dataReq = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (dataAck);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp, inout logic ok);
        assert (got === exp) else begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
            ok = 1'b0;
        end
    endtask

    initial begin
        TestRow row;
        logic [31:0] got, fetchGot;
        logic ok;
        int memReads;
        int memWrites;
        int txWrites;
        int startPulses;
        memReads = 0;
        memWrites = 0;
        txWrites = 0;
        fetchReq = 1'b0;
        fetchAddr = '0;
        dataReq = 1'b0;
        dataWE = 1'b0;
        dataAddr = '0;
        dataWriteData = '0;
        // isData, we, addr, wdata, expected, concurrent
        table_[0] = {1'b0, 1'b0, 32'h100, 32'h0, initContent(32'h100), 1'b0};
        table_[1] = {1'b1, 1'b0, 32'h200, 32'h0, initContent(32'h200), 1'b0};
        table_[2] = {1'b1, 1'b1, 32'h200, 32'hdead_beef, 32'h0, 1'b0};
        table_[3] = {1'b1, 1'b0, 32'h200, 32'h0, 32'hdead_beef, 1'b0};
        table_[4] = {1'b1, 1'b1, IO_TX, 32'h1234_5641, 32'h0, 1'b0};
        table_[5] = {1'b1, 1'b1, IO_TX, 32'h0000_0042, 32'h0, 1'b0};
        table_[6] = {1'b1, 1'b0, IO_STATUS, 32'h0, 32'h2, 1'b0};
        table_[7] = {1'b1, 1'b0, 32'h300, 32'h0, initContent(32'h300), 1'b1};
        table_[8] = {1'b1, 1'b0, 32'h200, 32'h0, 32'hdead_beef, 1'b1};
        table_[9] = {1'b0, 1'b0, 32'h200, 32'h0, 32'hdead_beef, 1'b0};

        wait (rstN);
        @(posedge clk);
        #1;
        ok = 1'b1;
        checkValue("fetchAck", {31'h0, fetchAck}, 32'h0, ok);
        checkValue("dataAck", {31'h0, dataAck}, 32'h0, ok);
        checkValue("memAccessRE", {31'h0, memAccessRE}, 32'h0, ok);
        checkValue("memAccessWE", {31'h0, memAccessWE}, 32'h0, ok);
        checkValue("serialWE", {31'h0, serialWE}, 32'h0, ok);
        checkValue("readCount", {16'h0, readCount}, 32'h0, ok);
        checkValue("writeCount", {16'h0, writeCount}, 32'h0, ok);
        checkValue("ioWriteCount", {16'h0, ioWriteCount}, 32'h0, ok);
        $display("reset state: %s", ok ? "ok" : "failed");

        for (int i = 0; i < NUM_ROWS; i++) begin
            row = table_[i];
            ok = 1'b1;
            startPulses = serialPulses;
            ioActive = row.isData && row.addr[31:28] == IO_TX[31:28];
            ioWriteLeaks = 0;
            if (row.conc) begin
                // The fetch reads the word 0x100 above the data address
                fork
                    fetchAccess(row.addr + 32'h100, fetchGot);
                    dataAccess(row.we, row.addr, row.wdata, got);
                join
                checkValue("fetchData", fetchGot, initContent(row.addr + 32'h100), ok);
                memReads = memReads + 1;
            end else if (row.isData) begin
                dataAccess(row.we, row.addr, row.wdata, got);
            end else begin
                fetchAccess(row.addr, got);
            end
            if (!row.we) checkValue(row.isData ? "dataReadData" : "fetchData",
                                    got, row.expData, ok);
            if (ioActive) begin
                assert (ioWriteLeaks == 0) else begin
                    $display("memAccessWE raised during an I/O access");
                    errors++;
                    ok = 1'b0;
                end
            end
            if (ioActive && row.we) begin
                txWrites = txWrites + 1;
                assert (serialPulses == startPulses + 1) else begin
                    $display("serialWE did not pulse once for a transmit write");
                    errors++;
                    ok = 1'b0;
                end
                checkValue("serialWriteData", {24'h0, serialByte}, {24'h0, row.wdata[7:0]}, ok);
            end else if (!ioActive && row.we) begin
                memWrites = memWrites + 1;
            end else if (!ioActive) begin
                memReads = memReads + 1;
            end
            $display("test %0d %s %s addr %h: %s", i, row.isData ? "data" : "fetch",
                     row.we ? "write" : "read", row.addr, ok ? "ok" : "failed");
        end
        ioActive = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        ok = 1'b1;
        checkValue("readCount", {16'h0, readCount}, memReads, ok);
        checkValue("writeCount", {16'h0, writeCount}, memWrites, ok);
        checkValue("ioWriteCount", {16'h0, ioWriteCount}, txWrites, ok);
        $display("counters: %s", ok ? "ok" : "failed");
        $display("%0d tests run, %0d errors", NUM_ROWS, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end
endmodule

// ==== compile.f ====
+incdir+common
common/MemorySystemTypes.sv
hw/MemoryAccessController/ReadSerialTable.sv
hw/MemoryAccessController/MemoryAccessController.sv
hw/IO_Unit.sv
hw/PerformanceCounter.sv
hw/MemorySystem.sv
testbench/ClockGen.sv
testbench/MemoryModel.sv
testbench/MemorySystem_chk.sv
testbench/MemorySystemTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the memory system testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f compile.f \
    --top-module MemorySystemTb -o simv

# The simulation status is judged from the log below
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "^STATUS: PASS$" sim.log; then
    exit 0
else
    echo "simulation did not pass"
    exit 1
fi
